// File: include/stream_defines.svh
`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

// --------------------------------------------------
// stream geometry.
// --------------------------------------------------
`define TDATA_WIDTH 32

// high half holds the burst sequence number.
`define SEQ_WIDTH (`TDATA_WIDTH / 2)

// --------------------------------------------------
// pattern timing.
// --------------------------------------------------
`define START_COUNT 32
`define BURST_WORDS 8

// fifo entries, also the initial credit count.
`define FIFO_DEPTH 4

`endif

// File: source/stream_pkg.sv
`include "stream_defines.svh"

package stream_pkg;

  // one stream data word.
  typedef logic [`TDATA_WIDTH-1:0] data_t;

  // word position inside a burst.
  typedef logic [$clog2(`BURST_WORDS + 1)-1:0] word_idx_t;

  // burst source states.
  typedef enum logic [1:0] {
    SRC_WAIT,
    SRC_SEND,
    SRC_DONE
  } src_state_t;

endpackage

// File: source/credit_pkg.sv
`include "stream_defines.svh"

package credit_pkg;

  // credits held by the source, 0 up to FIFO_DEPTH.
  typedef logic [$clog2(`FIFO_DEPTH + 1)-1:0] credit_t;

  // fifo read and write pointer.
  typedef logic [$clog2(`FIFO_DEPTH)-1:0] ptr_t;

endpackage

// File: source/burst_source.sv
`timescale 1ns/100ps

`include "stream_defines.svh"

module burst_source (
  input  logic              M_AXIS_ACLK,
  input  logic              M_AXIS_ARESETN,
  input  logic              credit_return,
  output logic              push,
  output stream_pkg::data_t push_data,
  output logic              push_last
);

  localparam int WAIT_W = $clog2(`START_COUNT);
  localparam int SEQ_W  = `SEQ_WIDTH;

  localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`START_COUNT - 1);
  localparam stream_pkg::word_idx_t IDX_LAST = stream_pkg::word_idx_t'(`BURST_WORDS - 1);
  localparam credit_pkg::credit_t CREDIT_FULL = credit_pkg::credit_t'(`FIFO_DEPTH);

  stream_pkg::src_state_t state;
  logic [WAIT_W-1:0]      wait_cnt;
  stream_pkg::word_idx_t  word_idx;
  logic [SEQ_W-1:0]       seq;
  credit_pkg::credit_t    credits;

  // --------------------------------------------------
  // push side, one word per cycle while credits last.
  // --------------------------------------------------
  assign push      = (state == stream_pkg::SRC_SEND) && (credits != '0);
  assign push_last = push && (word_idx == IDX_LAST);

  // low half counts from one.
  assign push_data = {seq, SEQ_W'(word_idx) + SEQ_W'(1)};

  // --------------------------------------------------
  // wait / send / done sequencing.
  // --------------------------------------------------
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state    <= stream_pkg::SRC_WAIT;
      wait_cnt <= '0;
      word_idx <= '0;
      seq      <= '0;
    end else begin
      case (state)
        stream_pkg::SRC_WAIT: begin
          if (wait_cnt == WAIT_LAST) begin
            wait_cnt <= '0;
            state    <= stream_pkg::SRC_SEND;
          end else begin
            wait_cnt <= wait_cnt + WAIT_W'(1);
          end
        end
        stream_pkg::SRC_SEND: begin
          if (push_last) begin
            word_idx <= '0;
            state    <= stream_pkg::SRC_DONE;
          end else if (push) begin
            word_idx <= word_idx + stream_pkg::word_idx_t'(1);
          end
        end
        stream_pkg::SRC_DONE: begin
          // let the fifo drain before the next gap starts.
          if (credits == CREDIT_FULL) begin
            seq   <= seq + SEQ_W'(1);
            state <= stream_pkg::SRC_WAIT;
          end
        end
        default: state <= stream_pkg::SRC_WAIT;
      endcase
    end
  end

  // --------------------------------------------------
  // credit counter.
  // --------------------------------------------------
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      credits <= CREDIT_FULL;
    end else if (push && !credit_return) begin
      credits <= credits - credit_pkg::credit_t'(1);
    end else if (!push && credit_return) begin
      credits <= credits + credit_pkg::credit_t'(1);
    end
  end

endmodule

// File: source/credit_fifo.sv
`timescale 1ns/100ps

`include "stream_defines.svh"

module credit_fifo (
  input  logic              M_AXIS_ACLK,
  input  logic              M_AXIS_ARESETN,
  input  logic              push,
  input  stream_pkg::data_t push_data,
  input  logic              push_last,
  input  logic              fifo_pop,
  output logic              fifo_valid,
  output stream_pkg::data_t fifo_data,
  output logic              fifo_last,
  output logic              credit_return
);

  localparam credit_pkg::ptr_t PTR_LAST = credit_pkg::ptr_t'(`FIFO_DEPTH - 1);

  stream_pkg::data_t   data_mem [`FIFO_DEPTH];
  logic                last_mem [`FIFO_DEPTH];
  credit_pkg::ptr_t    wr_ptr;
  credit_pkg::ptr_t    rd_ptr;
  credit_pkg::credit_t count;

  function automatic credit_pkg::ptr_t next_ptr(input credit_pkg::ptr_t ptr);
    if (ptr == PTR_LAST) begin
      return '0;
    end
    return ptr + credit_pkg::ptr_t'(1);
  endfunction

  // --------------------------------------------------
  // storage, written on push.
  // --------------------------------------------------
  always_ff @(posedge M_AXIS_ACLK) begin
    if (push) begin
      data_mem[wr_ptr] <= push_data;
      last_mem[wr_ptr] <= push_last;
    end
  end

  // head of queue, shown as soon as it lands.
  assign fifo_valid = (count != '0);
  assign fifo_data  = data_mem[rd_ptr];
  assign fifo_last  = last_mem[rd_ptr];

  // --------------------------------------------------
  // pointers and occupancy.
  // --------------------------------------------------
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (fifo_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !fifo_pop) begin
        count <= count + credit_pkg::credit_t'(1);
      end else if (!push && fifo_pop) begin
        count <= count - credit_pkg::credit_t'(1);
      end
      // each pop frees one slot for the source.
      credit_return <= fifo_pop;
    end
  end

endmodule

// File: source/axis_out_stage.sv
`timescale 1ns/100ps

`include "stream_defines.svh"

module axis_out_stage (
  input  logic                       M_AXIS_ACLK,
  input  logic                       M_AXIS_ARESETN,
  input  logic                       fifo_valid,
  input  stream_pkg::data_t          fifo_data,
  input  logic                       fifo_last,
  input  logic                       M_AXIS_TREADY,
  output logic                       fifo_pop,
  output logic                       M_AXIS_TVALID,
  output stream_pkg::data_t          M_AXIS_TDATA,
  output logic [`TDATA_WIDTH/8-1:0]  M_AXIS_TSTRB,
  output logic                       M_AXIS_TLAST
);

  logic              out_valid;
  stream_pkg::data_t out_data;
  logic              out_last;
  logic              load_ok;

  // register is free when empty or handing off this cycle.
  assign load_ok  = !out_valid || M_AXIS_TREADY;
  assign fifo_pop = fifo_valid && load_ok;

  // --------------------------------------------------
  // output register.
  // --------------------------------------------------
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      out_valid <= 1'b0;
    end else if (load_ok) begin
      out_valid <= fifo_valid;
    end
  end

  // payload holds while stalled.
  always_ff @(posedge M_AXIS_ACLK) begin
    if (fifo_pop) begin
      out_data <= fifo_data;
      out_last <= fifo_last;
    end
  end

  assign M_AXIS_TVALID = out_valid;
  assign M_AXIS_TDATA  = out_data;
  assign M_AXIS_TLAST  = out_last;
  assign M_AXIS_TSTRB  = '1;

endmodule

// File: source/stream_master_top.sv
`timescale 1ns/100ps

`include "stream_defines.svh"

module stream_master_top (
  input  logic                       M_AXIS_ACLK,
  input  logic                       M_AXIS_ARESETN,
  output logic                       M_AXIS_TVALID,
  output stream_pkg::data_t          M_AXIS_TDATA,
  output logic [`TDATA_WIDTH/8-1:0]  M_AXIS_TSTRB,
  output logic                       M_AXIS_TLAST,
  input  logic                       M_AXIS_TREADY
);

  // source to fifo.
  logic              push;
  stream_pkg::data_t push_data;
  logic              push_last;
  logic              credit_return;

  // fifo to output stage.
  logic              fifo_valid;
  stream_pkg::data_t fifo_data;
  logic              fifo_last;
  logic              fifo_pop;

  // --------------------------------------------------
  // pattern source -> credit fifo -> output register.
  // --------------------------------------------------
  burst_source burst_source_i (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .credit_return  (credit_return),
    .push           (push),
    .push_data      (push_data),
    .push_last      (push_last)
  );

  credit_fifo credit_fifo_i (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .push           (push),
    .push_data      (push_data),
    .push_last      (push_last),
    .fifo_pop       (fifo_pop),
    .fifo_valid     (fifo_valid),
    .fifo_data      (fifo_data),
    .fifo_last      (fifo_last),
    .credit_return  (credit_return)
  );

  axis_out_stage axis_out_stage_i (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .fifo_valid     (fifo_valid),
    .fifo_data      (fifo_data),
    .fifo_last      (fifo_last),
    .M_AXIS_TREADY  (M_AXIS_TREADY),
    .fifo_pop       (fifo_pop),
    .M_AXIS_TVALID  (M_AXIS_TVALID),
    .M_AXIS_TDATA   (M_AXIS_TDATA),
    .M_AXIS_TSTRB   (M_AXIS_TSTRB),
    .M_AXIS_TLAST   (M_AXIS_TLAST)
  );

endmodule

// File: sim/tb_stream_master.sv
`timescale 1ns/100ps

`include "stream_defines.svh"

module tb_stream_master;

  localparam int SEQ_W          = `SEQ_WIDTH;
  localparam int NUM_BURSTS     = 8;
  localparam int STALL_CYCLES   = 60;
  localparam int TIMEOUT_CYCLES = 16 + NUM_BURSTS * (`START_COUNT + 4 * `BURST_WORDS)
                                  + STALL_CYCLES + 200;
  localparam logic [31:0] STRB_ALL = 32'((1 << (`TDATA_WIDTH / 8)) - 1);

  logic                      clk;
  logic                      aresetn;
  logic                      m_axis_tready;
  logic                      m_axis_tvalid;
  logic [`TDATA_WIDTH-1:0]   m_axis_tdata;
  logic [`TDATA_WIDTH/8-1:0] m_axis_tstrb;
  logic                      m_axis_tlast;

  int seed;
  int check_count;
  int error_count;
  int timeout_count;

  // reference model and monitor state.
  int                      cycle;
  int                      words_seen;
  int                      bursts_seen;
  int                      exp_idx;
  int                      last_hs_cycle;
  logic [SEQ_W-1:0]        exp_seq;
  logic                    gap_armed;
  logic                    gap_check_en;
  logic                    prev_valid;
  logic                    prev_ready;
  logic                    prev_last;
  logic [`TDATA_WIDTH-1:0] prev_data;

  stream_master_top stream_master_top_i (
    .M_AXIS_ACLK    (clk),
    .M_AXIS_ARESETN (aresetn),
    .M_AXIS_TVALID  (m_axis_tvalid),
    .M_AXIS_TDATA   (m_axis_tdata),
    .M_AXIS_TSTRB   (m_axis_tstrb),
    .M_AXIS_TLAST   (m_axis_tlast),
    .M_AXIS_TREADY  (m_axis_tready)
  );

  always #2 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s, at time %0t", msg, $time);
  endtask

  // --------------------------------------------------
  // monitor and model.
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!aresetn) begin
      cycle      <= 0;
      words_seen <= 0;
      bursts_seen <= 0;
      exp_idx    <= 0;
      exp_seq    <= '0;
      gap_armed  <= 1'b0;
      prev_valid <= 1'b0;
      prev_ready <= 1'b0;
    end else begin
      cycle <= cycle + 1;
      // stalled word must hold.
      if (prev_valid && !prev_ready) begin
        check_value("M_AXIS_TVALID", 32'd1, 32'(m_axis_tvalid));
        check_value("M_AXIS_TDATA", prev_data, m_axis_tdata);
        check_value("M_AXIS_TLAST", 32'(prev_last), 32'(m_axis_tlast));
      end
      if (m_axis_tvalid && !prev_valid && gap_armed) begin
        if (cycle - last_hs_cycle - 1 < `START_COUNT) begin
          report_failure($sformatf("burst started only %0d cycles after TLAST",
                                   cycle - last_hs_cycle - 1));
        end
        gap_armed <= 1'b0;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        check_value("M_AXIS_TDATA", {exp_seq, SEQ_W'(exp_idx + 1)}, m_axis_tdata);
        check_value("M_AXIS_TLAST", 32'(exp_idx == `BURST_WORDS - 1), 32'(m_axis_tlast));
        check_value("M_AXIS_TSTRB", STRB_ALL, 32'(m_axis_tstrb));
        words_seen <= words_seen + 1;
        if (exp_idx == `BURST_WORDS - 1) begin
          exp_idx       <= 0;
          exp_seq       <= exp_seq + SEQ_W'(1);
          bursts_seen   <= bursts_seen + 1;
          last_hs_cycle <= cycle;
          gap_armed     <= gap_check_en;
        end else begin
          exp_idx <= exp_idx + 1;
        end
      end
      prev_valid <= m_axis_tvalid;
      prev_ready <= m_axis_tready;
      prev_data  <= m_axis_tdata;
      prev_last  <= m_axis_tlast;
    end
  end

  always @(posedge clk) begin
    timeout_count <= timeout_count + 1;
    if (timeout_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", check_count, error_count + 1);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // directed tests.
  // --------------------------------------------------
  task automatic reset_quiet_test();
    int delay;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      if (i > 0) begin
        check_value("M_AXIS_TVALID", 32'd0, 32'(m_axis_tvalid));
      end
    end
    aresetn       <= 1'b1;
    m_axis_tready <= 1'b1;
    gap_check_en  <= 1'b1;
    delay = 0;
    @(posedge clk);
    while (!m_axis_tvalid) begin
      @(posedge clk);
      delay++;
    end
    if (delay < `START_COUNT) begin
      report_failure($sformatf("TVALID rose %0d cycles after reset", delay));
    end
  endtask

  task automatic run_bursts_ready_high(input int count);
    int target;
    target = bursts_seen + count;
    m_axis_tready <= 1'b1;
    gap_check_en  <= 1'b1;
    while (bursts_seen < target) @(posedge clk);
    // nothing follows TLAST until the next gap.
    check_value("M_AXIS_TVALID", 32'd0, 32'(m_axis_tvalid));
  endtask

  task automatic random_ready_test();
    int target;
    int rnd;
    target = bursts_seen + 3;
    gap_check_en <= 1'b0;
    while (bursts_seen < target) begin
      @(posedge clk);
      rnd = $random(seed);
      m_axis_tready <= rnd[0];
    end
    check_value("M_AXIS_TVALID", 32'd0, 32'(m_axis_tvalid));
  endtask

  task automatic long_stall_test();
    int target;
    target = words_seen + 3;
    m_axis_tready <= 1'b1;
    gap_check_en  <= 1'b1;
    while (words_seen < target) @(posedge clk);
    // fifo fills and the source runs out of credits.
    m_axis_tready <= 1'b0;
    repeat (STALL_CYCLES) @(posedge clk);
    run_bursts_ready_high(1);
  endtask

  initial begin
    clk           = 1'b0;
    aresetn       = 1'b0;
    m_axis_tready = 1'b0;
    gap_check_en  = 1'b0;
    seed          = 32'h8cc18f7f;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;

    reset_quiet_test();
    run_bursts_ready_high(1);
    run_bursts_ready_high(1);
    random_ready_test();
    run_bursts_ready_high(2);
    long_stall_test();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
source/stream_pkg.sv
source/credit_pkg.sv
source/burst_source.sv
source/credit_fifo.sv
source/axis_out_stage.sv
source/stream_master_top.sv
sim/tb_stream_master.sv

// File: Makefile
# Verilator flow for the AXI4-Stream pattern master.

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= tb_stream_master
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
